// ==== ycc_rgb_top.f ====
rtl/ycc_rgb_pkg.sv
rtl/ycc_cfg_regs.sv
rtl/mcu_store.sv
rtl/mcu_scan.sv
rtl/color_convert.sv
rtl/pixel_out_fifo.sv
rtl/ycc_rgb_top.sv
sim/ycc_rgb_tb.sv

// ==== Makefile ====
# Verilator build and run for the YCbCr to RGB stage

VERILATOR ?= verilator
TOP ?= ycc_rgb_tb
FLIST ?= ycc_rgb_top.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$($(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/ycc_rgb_tb.sv ====
`default_nettype none

module ycc_rgb_tb;
	import ycc_rgb_pkg::*;

	localparam int N_TESTS = 6;
	// 2x1 444, 1x2 420, 2x1 420, 3x1 420, 1x1 444
	localparam int TOTAL_PIX = 2 * 64 + 2 * 256 + 2 * 256 + 3 * 256 + 64;
	localparam int CYCLE_LIMIT = 4 * TOTAL_PIX + 500 * N_TESTS;

	logic clk;
	logic rst;
	logic psel;
	logic penable;
	logic pwrite;
	logic [3:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pslverr;
	logic row_valid;
	logic [127:0] row_data;
	logic row_ready;
	logic px_valid;
	logic [7:0] px_r;
	logic [7:0] px_g;
	logic [7:0] px_b;
	logic [7:0] px_idx;
	logic [12:0] px_mcu_x;
	logic [12:0] px_mcu_y;
	logic px_first;
	logic px_last;
	logic px_ready = 1'b0;

	integer seed;
	int errors;
	int px_errors;
	int checks;
	int pix_checks;
	int cycles = 0;
	int err_base;
	int samp [0:5][0:63];
	int mdl_w;
	int mdl_h;
	logic ready_rand;
	logic ready_level;

	// expected pixels, {r, g, b, idx, x, y, first, last}
	logic [59:0] exp_q [$];
	logic exp_valid = 1'b0;
	logic [7:0] exp_r;
	logic [7:0] exp_g;
	logic [7:0] exp_b;
	logic [7:0] exp_idx;
	logic [12:0] exp_x;
	logic [12:0] exp_y;
	logic exp_first;
	logic exp_last;

	logic taking = 1'b0;
	logic stall_now = 1'b0;
	logic stall_prev = 1'b0;
	logic [59:0] px_word;
	logic [59:0] word_now;
	logic [59:0] word_prev;

	assign px_word = {px_r, px_g, px_b, px_idx, px_mcu_x, px_mcu_y, px_first, px_last};

	ycc_rgb_top i_dut (
		.clk(clk), .rst(rst),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pslverr(pslverr),
		.row_valid(row_valid), .row_data(row_data), .row_ready(row_ready),
		.px_valid(px_valid), .px_r(px_r), .px_g(px_g), .px_b(px_b),
		.px_idx(px_idx), .px_mcu_x(px_mcu_x), .px_mcu_y(px_mcu_y),
		.px_first(px_first), .px_last(px_last), .px_ready(px_ready)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: run stopped after %0d cycles with pixels still missing", cycles);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	always @(posedge clk) begin
		#1;
		if (ready_rand) begin
			px_ready = ($random(seed) & 1) != 0;
		end else begin
			px_ready = ready_level;
		end
	end

	// outputs are stable at the falling edge
	always @(negedge clk) begin
		taking = !rst && px_valid && px_ready;
		stall_now = !rst && px_valid && !px_ready;
		word_now = px_word;
	end

	always @(posedge clk) begin
		#2;
		stall_prev = stall_now;
		word_prev = word_now;
		if (taking && exp_q.size() != 0) begin
			pix_checks++;
			void'(exp_q.pop_front());
		end
		exp_valid = exp_q.size() != 0;
		if (exp_valid) begin
			{exp_r, exp_g, exp_b, exp_idx, exp_x, exp_y, exp_first, exp_last} = exp_q[0];
		end
	end

	// ------------------------------------------------------------------
	// output checks
	// ------------------------------------------------------------------
	a_px_known: assert property (@(negedge clk) disable iff (rst)
		px_valid && px_ready |-> exp_valid)
	else begin
		px_errors++;
		$display("a pixel was transferred when none was expected");
	end

	a_px_rgb: assert property (@(negedge clk) disable iff (rst)
		px_valid && px_ready && exp_valid |-> {px_r, px_g, px_b} == {exp_r, exp_g, exp_b})
	else begin
		px_errors++;
		$display("error px_r/px_g/px_b: got %h %h %h expected %h %h %h",
			px_r, px_g, px_b, exp_r, exp_g, exp_b);
	end

	a_px_idx: assert property (@(negedge clk) disable iff (rst)
		px_valid && px_ready && exp_valid |-> px_idx == exp_idx)
	else begin
		px_errors++;
		$display("error px_idx: got %h expected %h", px_idx, exp_idx);
	end

	a_px_pos: assert property (@(negedge clk) disable iff (rst)
		px_valid && px_ready && exp_valid |-> px_mcu_x == exp_x && px_mcu_y == exp_y)
	else begin
		px_errors++;
		$display("error px_mcu_x/px_mcu_y: got %h %h expected %h %h",
			px_mcu_x, px_mcu_y, exp_x, exp_y);
	end

	a_px_flags: assert property (@(negedge clk) disable iff (rst)
		px_valid && px_ready && exp_valid |-> px_first == exp_first && px_last == exp_last)
	else begin
		px_errors++;
		$display("error px_first/px_last: got %h %h expected %h %h",
			px_first, px_last, exp_first, exp_last);
	end

	a_hold_valid: assert property (@(negedge clk) disable iff (rst)
		stall_prev |-> px_valid)
	else begin
		px_errors++;
		$display("px_valid dropped while a pixel was stalled");
	end

	a_hold_word: assert property (@(negedge clk) disable iff (rst)
		stall_prev && px_valid |-> px_word == word_prev)
	else begin
		px_errors++;
		$display("error px_word: got %h expected %h while stalled", px_word, word_prev);
	end

	// ------------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------------
	function automatic int floor_4096(input int v);
		if (v >= 0) begin
			return v / 4096;
		end
		return -((-v + 4095) / 4096);
	endfunction

	function automatic logic [7:0] clamp_u8(input int v);
		if (v < 0) begin
			return 8'h00;
		end else if (v > 255) begin
			return 8'hff;
		end
		return 8'(v);
	endfunction

	// mostly small values, with the extremes mixed in
	function automatic int new_sample();
		int pick;
		pick = $random(seed) & 15;
		case (pick)
			0: return 2047;
			1: return -2047;
			2: return 0;
			default: return $random(seed) % 256;
		endcase
	endfunction

	function automatic logic [127:0] row_bits(input int blk, input int row);
		logic [127:0] bits;
		for (int i = 0; i < 8; i++) begin
			bits[i*16 +: 16] = 16'(samp[blk][row*8+i]);
		end
		return bits;
	endfunction

	task automatic push_expected(input logic m420, input int mx, input int my);
		int n;
		int nb;
		int row;
		int col;
		int yv;
		int cbv;
		int crv;
		int ci;
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
		logic first;
		logic last;
		nb = m420 ? 4 : 1;
		n = m420 ? 256 : 64;
		for (int p = 0; p < n; p++) begin
			if (m420) begin
				row = p / 16;
				col = p % 16;
				yv = samp[(row / 8) * 2 + col / 8][(row % 8) * 8 + col % 8];
				ci = (row / 2) * 8 + col / 2;
			end else begin
				yv = samp[0][p];
				ci = p;
			end
			cbv = samp[nb][ci];
			crv = samp[nb+1][ci];
			r = clamp_u8(128 + yv + floor_4096(5742 * crv));
			g = clamp_u8(128 + yv - floor_4096(1409 * cbv) - floor_4096(2925 * crv));
			b = clamp_u8(128 + yv + floor_4096(7258 * cbv));
			first = p == 0 && mx == 0 && my == 0;
			last = p == n - 1 && mx == mdl_w - 1 && my == mdl_h - 1;
			exp_q.push_back({r, g, b, 8'(p), 13'(mx), 13'(my), first, last});
		end
	endtask

	// ------------------------------------------------------------------
	// bus and stream drivers
	// ------------------------------------------------------------------
	task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = addr;
		pwdata = wdata;
		@(posedge clk);
		#1;
		penable = 1'b1;
		@(negedge clk);
		rdata = prdata;
		err = pslverr;
		@(posedge clk);
		#1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
		logic [31:0] rd;
		logic err;
		apb_access(1'b1, addr, data, rd, err);
		checks++;
		assert (!err) else begin
			errors++;
			$display("error pslverr: got %h expected 0 on write to %h", err, addr);
		end
	endtask

	task automatic check_reg(input logic [3:0] addr, input logic [31:0] expected);
		logic [31:0] rd;
		logic err;
		apb_access(1'b0, addr, 32'h0, rd, err);
		checks++;
		assert (rd == expected && !err) else begin
			errors++;
			$display("error prdata: got %h expected %h at %h, pslverr %h", rd, expected,
				addr, err);
		end
	endtask

	task automatic send_row(input logic [127:0] bits);
		row_valid = 1'b1;
		row_data = bits;
		@(negedge clk);
		while (!row_ready) begin
			@(negedge clk);
		end
		@(posedge clk);
		#1;
		row_valid = 1'b0;
	endtask

	task automatic send_mcu(input logic m420, input int mx, input int my);
		int nb;
		nb = m420 ? 6 : 3;
		for (int blk = 0; blk < nb; blk++) begin
			for (int k = 0; k < 64; k++) begin
				samp[blk][k] = new_sample();
			end
		end
		push_expected(m420, mx, my);
		for (int blk = 0; blk < nb; blk++) begin
			for (int row = 0; row < 8; row++) begin
				send_row(row_bits(blk, row));
			end
		end
	endtask

	task automatic configure(input logic m420, input int w, input int h);
		write_reg(ADDR_CTRL, {31'b0, m420});
		write_reg(ADDR_MCU_W, 32'(w));
		write_reg(ADDR_MCU_H, 32'(h));
		mdl_w = w;
		mdl_h = h;
	endtask

	task automatic drain();
		while (exp_q.size() != 0) begin
			@(posedge clk);
		end
		repeat (4) @(posedge clk);
		#1;
		checks++;
		assert (!px_valid) else begin
			errors++;
			$display("an extra pixel is still on the output after the frame");
		end
	endtask

	task automatic run_frame(input logic m420, input int w, input int h);
		configure(m420, w, h);
		for (int my = 0; my < h; my++) begin
			for (int mx = 0; mx < w; mx++) begin
				send_mcu(m420, mx, my);
			end
		end
		drain();
	endtask

	task automatic end_test(input int num, input string name);
		$display("test %0d %s: %0d errors", num, name, errors + px_errors - err_base);
		err_base = errors + px_errors;
	endtask

	// ------------------------------------------------------------------
	// tests
	// ------------------------------------------------------------------
	initial begin
		logic [31:0] rd;
		logic err;
		seed = 32'hc701;
		errors = 0;
		px_errors = 0;
		checks = 0;
		pix_checks = 0;
		err_base = 0;
		rst = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		row_valid = 1'b0;
		row_data = '0;
		ready_rand = 1'b0;
		ready_level = 1'b0;
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;

		check_reg(ADDR_MCU_W, 32'h1);
		write_reg(ADDR_CTRL, 32'hffff_ffff);
		check_reg(ADDR_CTRL, 32'h1);
		write_reg(ADDR_MCU_W, 32'hffff_ffff);
		check_reg(ADDR_MCU_W, 32'h1fff);
		write_reg(ADDR_MCU_H, 32'h1234_5678);
		check_reg(ADDR_MCU_H, 32'h1678);
		apb_access(1'b1, 4'h6, 32'hffff_ffff, rd, err);
		checks++;
		assert (err) else begin
			errors++;
			$display("write to unmapped address 6 did not raise pslverr");
		end
		apb_access(1'b0, 4'h2, 32'h0, rd, err);
		checks++;
		assert (err) else begin
			errors++;
			$display("read of unmapped address 2 did not raise pslverr");
		end
		end_test(1, "register access");

		ready_level = 1'b1;
		run_frame(1'b0, 2, 1);
		end_test(2, "4:4:4 frame 2x1");

		run_frame(1'b1, 1, 2);
		end_test(3, "4:2:0 frame 1x2");

		ready_rand = 1'b1;
		run_frame(1'b1, 2, 1);
		ready_rand = 1'b0;
		end_test(4, "back-pressure");

		// both banks fill while the output is stalled
		ready_level = 1'b0;
		configure(1'b1, 3, 1);
		send_mcu(1'b1, 0, 0);
		send_mcu(1'b1, 1, 0);
		repeat (2) begin
			@(negedge clk);
			checks++;
			assert (!row_ready && px_valid) else begin
				errors++;
				$display("error row_ready/px_valid: got %h %h expected 0 1", row_ready,
					px_valid);
			end
		end
		@(posedge clk);
		#1;
		ready_level = 1'b1;
		send_mcu(1'b1, 2, 0);
		drain();
		end_test(5, "ping-pong");

		write_reg(ADDR_STATUS, 32'h1);
		check_reg(ADDR_STATUS, 32'h0);
		run_frame(1'b0, 1, 1);
		check_reg(ADDR_STATUS, 32'h1);
		write_reg(ADDR_STATUS, 32'h0);
		check_reg(ADDR_STATUS, 32'h1);
		write_reg(ADDR_STATUS, 32'h1);
		check_reg(ADDR_STATUS, 32'h0);
		end_test(6, "frame status");

		$display("tests %0d, checks %0d, pixels %0d, errors %0d", N_TESTS, checks, pix_checks,
			errors + px_errors);
		if (errors + px_errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== rtl/ycc_rgb_top.sv ====
`default_nettype none

module ycc_rgb_top #(
	parameter int FIFO_DEPTH = 2
) (
	input logic clk,
	input logic rst,
	// apb
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [3:0] paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pslverr,
	// block rows in
	input logic row_valid,
	input logic [ycc_rgb_pkg::ROW_W-1:0] row_data,
	output logic row_ready,
	// pixels out
	output logic px_valid,
	output logic [ycc_rgb_pkg::COLOR_W-1:0] px_r,
	output logic [ycc_rgb_pkg::COLOR_W-1:0] px_g,
	output logic [ycc_rgb_pkg::COLOR_W-1:0] px_b,
	output ycc_rgb_pkg::pix_idx_u px_idx,
	output logic [ycc_rgb_pkg::MCU_POS_W-1:0] px_mcu_x,
	output logic [ycc_rgb_pkg::MCU_POS_W-1:0] px_mcu_y,
	output logic px_first,
	output logic px_last,
	input logic px_ready
);
	import ycc_rgb_pkg::*;

	logic mode_420;
	logic [MCU_POS_W-1:0] mcu_w;
	logic [MCU_POS_W-1:0] mcu_h;
	logic frame_end;
	logic rd_ready;
	logic rd_done;
	pix_idx_u y_addr;
	logic [5:0] c_addr;
	logic signed [SAMPLE_W-1:0] y_data;
	logic signed [SAMPLE_W-1:0] cb_data;
	logic signed [SAMPLE_W-1:0] cr_data;
	logic [COLOR_W-1:0] r;
	logic [COLOR_W-1:0] g;
	logic [COLOR_W-1:0] b;
	logic fifo_wr;
	logic fifo_full;
	pix_idx_u scan_idx;
	logic [MCU_POS_W-1:0] scan_x;
	logic [MCU_POS_W-1:0] scan_y;
	logic scan_first;
	logic scan_last;
	logic [PIX_WORD_W-1:0] fifo_din;
	logic [PIX_WORD_W-1:0] fifo_dout;

	assign frame_end = px_valid & px_ready & px_last;

	// ------------------------------------------------------------------
	// config and sample store
	// ------------------------------------------------------------------
	ycc_cfg_regs i_cfg (
		.clk(clk), .rst(rst),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pslverr(pslverr),
		.frame_end(frame_end),
		.mode_420(mode_420), .mcu_w(mcu_w), .mcu_h(mcu_h)
	);

	mcu_store i_store (
		.clk(clk), .rst(rst), .mode_420(mode_420),
		.row_valid(row_valid), .row_data(row_data), .row_ready(row_ready),
		.rd_done(rd_done), .rd_ready(rd_ready), .rd_bank(),
		.y_addr(y_addr), .c_addr(c_addr),
		.y_data(y_data), .cb_data(cb_data), .cr_data(cr_data)
	);

	// ------------------------------------------------------------------
	// scan, convert, output queue
	// ------------------------------------------------------------------
	mcu_scan i_scan (
		.clk(clk), .rst(rst), .mode_420(mode_420),
		.mcu_w(mcu_w), .mcu_h(mcu_h),
		.rd_ready(rd_ready), .rd_done(rd_done),
		.y_addr(y_addr), .c_addr(c_addr),
		.fifo_full(fifo_full), .fifo_wr(fifo_wr),
		.pix_idx(scan_idx), .mcu_x(scan_x), .mcu_y(scan_y),
		.first(scan_first), .last(scan_last)
	);

	color_convert i_conv (
		.y(y_data), .cb(cb_data), .cr(cr_data),
		.r(r), .g(g), .b(b)
	);

	assign fifo_din = {r, g, b, scan_idx, scan_x, scan_y, scan_first, scan_last};

	pixel_out_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) i_fifo (
		.clk(clk), .rst(rst),
		.wr(fifo_wr), .din(fifo_din), .full(fifo_full),
		.px_ready(px_ready), .px_valid(px_valid), .dout(fifo_dout)
	);

	assign {px_r, px_g, px_b, px_idx, px_mcu_x, px_mcu_y, px_first, px_last} = fifo_dout;

endmodule

`default_nettype wire

// ==== rtl/pixel_out_fifo.sv ====
`default_nettype none

module pixel_out_fifo #(
	parameter int FIFO_DEPTH = 2
) (
	input logic clk,
	input logic rst,
	input logic wr,
	input logic [ycc_rgb_pkg::PIX_WORD_W-1:0] din,
	output logic full,
	input logic px_ready,
	output logic px_valid,
	output logic [ycc_rgb_pkg::PIX_WORD_W-1:0] dout
);
	import ycc_rgb_pkg::*;

	localparam int PTR_W = $clog2(FIFO_DEPTH);
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	logic [PIX_WORD_W-1:0] mem [0:FIFO_DEPTH-1];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic push;
	logic pop;

	// depth need not be a power of two
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + PTR_W'(1);
	endfunction

	assign full = count == CNT_W'(FIFO_DEPTH);
	assign px_valid = count != '0;
	assign push = wr & ~full;
	assign pop = px_valid & px_ready;
	assign dout = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= din;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			count <= count + CNT_W'(push) - CNT_W'(pop);
		end
	end

endmodule

`default_nettype wire

// ==== rtl/color_convert.sv ====
`default_nettype none

module color_convert (
	input logic signed [ycc_rgb_pkg::SAMPLE_W-1:0] y,
	input logic signed [ycc_rgb_pkg::SAMPLE_W-1:0] cb,
	input logic signed [ycc_rgb_pkg::SAMPLE_W-1:0] cr,
	output logic [ycc_rgb_pkg::COLOR_W-1:0] r,
	output logic [ycc_rgb_pkg::COLOR_W-1:0] g,
	output logic [ycc_rgb_pkg::COLOR_W-1:0] b
);
	import ycc_rgb_pkg::*;

	localparam int FRAC = 12;
	localparam int PROD_W = SAMPLE_W + 14;
	localparam int SUM_W = 20;

	// constant multiply as a sum of shifted copies
	function automatic logic signed [PROD_W-1:0] mul_k(input logic signed [SAMPLE_W-1:0] x,
		input logic [12:0] k);
		logic signed [PROD_W-1:0] xe;
		logic signed [PROD_W-1:0] acc;
		xe = PROD_W'(x);
		acc = '0;
		for (int i = 0; i < 13; i++) begin
			if (k[i]) begin
				acc = acc + (xe <<< i);
			end
		end
		return acc;
	endfunction

	function automatic logic [COLOR_W-1:0] clamp(input logic signed [SUM_W-1:0] v);
		if (v < 0) begin
			return '0;
		end else if (v > (2 ** COLOR_W - 1)) begin
			return '1;
		end
		return v[COLOR_W-1:0];
	endfunction

	logic signed [PROD_W-1:0] cr_r;
	logic signed [PROD_W-1:0] cb_g;
	logic signed [PROD_W-1:0] cr_g;
	logic signed [PROD_W-1:0] cb_b;
	logic signed [SUM_W-1:0] y_ls;
	logic signed [SUM_W-1:0] r_sum;
	logic signed [SUM_W-1:0] g_sum;
	logic signed [SUM_W-1:0] b_sum;

	assign cr_r = mul_k(cr, K_CR_R);
	assign cb_g = mul_k(cb, K_CB_G);
	assign cr_g = mul_k(cr, K_CR_G);
	assign cb_b = mul_k(cb, K_CB_B);

	assign y_ls = SUM_W'(y) + SUM_W'(LEVEL_SHIFT);

	// arithmetic shift gives floor of the scaled product
	assign r_sum = y_ls + SUM_W'(cr_r >>> FRAC);
	assign g_sum = y_ls - SUM_W'(cb_g >>> FRAC) - SUM_W'(cr_g >>> FRAC);
	assign b_sum = y_ls + SUM_W'(cb_b >>> FRAC);

	assign r = clamp(r_sum);
	assign g = clamp(g_sum);
	assign b = clamp(b_sum);

endmodule

`default_nettype wire

// ==== rtl/mcu_scan.sv ====
`default_nettype none

module mcu_scan (
	input logic clk,
	input logic rst,
	input logic mode_420,
	input logic [ycc_rgb_pkg::MCU_POS_W-1:0] mcu_w,
	input logic [ycc_rgb_pkg::MCU_POS_W-1:0] mcu_h,
	input logic rd_ready,
	output logic rd_done,
	output ycc_rgb_pkg::pix_idx_u y_addr,
	output logic [5:0] c_addr,
	input logic fifo_full,
	output logic fifo_wr,
	output ycc_rgb_pkg::pix_idx_u pix_idx,
	output logic [ycc_rgb_pkg::MCU_POS_W-1:0] mcu_x,
	output logic [ycc_rgb_pkg::MCU_POS_W-1:0] mcu_y,
	output logic first,
	output logic last
);
	import ycc_rgb_pkg::*;

	logic busy;
	pix_idx_u idx;
	logic last_pix;
	logic last_x;
	logic last_y;

	assign last_pix = mode_420 ? idx.raw == 8'hff : idx.raw == 8'h3f;
	assign last_x = mcu_x == mcu_w - MCU_POS_W'(1);
	assign last_y = mcu_y == mcu_h - MCU_POS_W'(1);

	assign fifo_wr = busy & ~fifo_full;
	assign rd_done = fifo_wr & last_pix;

	assign y_addr = idx;
	assign pix_idx = idx;
	// chroma is subsampled 2x2 in 4:2:0
	assign c_addr = mode_420 ? {idx.v420.row[3:1], idx.v420.col[3:1]}
		: {idx.v444.row, idx.v444.col};

	assign first = idx.raw == '0 && mcu_x == '0 && mcu_y == '0;
	assign last = last_pix & last_x & last_y;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			idx <= '0;
			mcu_x <= '0;
			mcu_y <= '0;
		end else begin
			if (!busy && rd_ready) begin
				busy <= 1'b1;
			end
			if (fifo_wr) begin
				idx.raw <= last_pix ? '0 : idx.raw + 8'd1;
			end
			// mcu fully issued, step the frame position
			if (rd_done) begin
				busy <= 1'b0;
				if (last_x) begin
					mcu_x <= '0;
					mcu_y <= last_y ? '0 : mcu_y + MCU_POS_W'(1);
				end else begin
					mcu_x <= mcu_x + MCU_POS_W'(1);
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/mcu_store.sv ====
`default_nettype none

module mcu_store (
	input logic clk,
	input logic rst,
	input logic mode_420,
	input logic row_valid,
	input logic [ycc_rgb_pkg::ROW_W-1:0] row_data,
	output logic row_ready,
	input logic rd_done,
	output logic rd_ready,
	output logic rd_bank,
	input ycc_rgb_pkg::pix_idx_u y_addr,
	input logic [5:0] c_addr,
	output logic signed [ycc_rgb_pkg::SAMPLE_W-1:0] y_data,
	output logic signed [ycc_rgb_pkg::SAMPLE_W-1:0] cb_data,
	output logic signed [ycc_rgb_pkg::SAMPLE_W-1:0] cr_data
);
	import ycc_rgb_pkg::*;

	// bank in the top address bit
	logic signed [SAMPLE_W-1:0] y_mem [0:511];
	logic signed [SAMPLE_W-1:0] cb_mem [0:127];
	logic signed [SAMPLE_W-1:0] cr_mem [0:127];

	logic run;
	logic wr_bank;
	logic [1:0] full;
	logic [2:0] wr_row;
	logic [2:0] wr_blk;
	logic [2:0] last_blk;
	logic row_fire;
	logic mcu_done;
	logic is_y;
	logic is_cb;
	logic is_cr;
	logic [4:0] y_row_base;

	// ------------------------------------------------------------------
	// write side
	// ------------------------------------------------------------------
	assign row_ready = run & ~full[wr_bank];
	assign row_fire = row_valid & row_ready;
	assign last_blk = mode_420 ? 3'd5 : 3'd2;
	assign mcu_done = row_fire && wr_row == 3'd7 && wr_blk == last_blk;

	assign is_y = mode_420 ? ~wr_blk[2] : wr_blk == 3'd0;
	assign is_cb = wr_blk == (mode_420 ? 3'd4 : 3'd1);
	assign is_cr = wr_blk == last_blk;

	// luma row start, upper address bits
	// 4:2:0 block bit 1 selects lower half, bit 0 right half
	assign y_row_base = mode_420 ? {wr_blk[1], wr_row, wr_blk[0]} : {2'b00, wr_row};

	always_ff @(posedge clk) begin
		if (row_fire) begin
			for (int i = 0; i < ROW_SAMPLES; i++) begin
				if (is_y) begin
					y_mem[{wr_bank, y_row_base, 3'(i)}] <= row_data[i*SAMPLE_W +: SAMPLE_W];
				end
				if (is_cb) begin
					cb_mem[{wr_bank, wr_row, 3'(i)}] <= row_data[i*SAMPLE_W +: SAMPLE_W];
				end
				if (is_cr) begin
					cr_mem[{wr_bank, wr_row, 3'(i)}] <= row_data[i*SAMPLE_W +: SAMPLE_W];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			run <= 1'b0;
			wr_bank <= 1'b0;
			rd_bank <= 1'b0;
			full <= '0;
			wr_row <= '0;
			wr_blk <= '0;
		end else begin
			run <= 1'b1;
			if (row_fire) begin
				wr_row <= wr_row + 3'd1;
				if (wr_row == 3'd7) begin
					wr_blk <= mcu_done ? 3'd0 : wr_blk + 3'd1;
				end
			end
			if (mcu_done) begin
				full[wr_bank] <= 1'b1;
				wr_bank <= ~wr_bank;
			end
			// a bank being filled is never the full one being drained
			if (rd_done) begin
				full[rd_bank] <= 1'b0;
				rd_bank <= ~rd_bank;
			end
		end
	end

	// ------------------------------------------------------------------
	// read side
	// ------------------------------------------------------------------
	assign rd_ready = full[rd_bank];
	assign y_data = y_mem[{rd_bank, y_addr.raw}];
	assign cb_data = cb_mem[{rd_bank, c_addr}];
	assign cr_data = cr_mem[{rd_bank, c_addr}];

endmodule

`default_nettype wire

// ==== rtl/ycc_cfg_regs.sv ====
`default_nettype none

module ycc_cfg_regs (
	input logic clk,
	input logic rst,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [3:0] paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pslverr,
	input logic frame_end,
	output logic mode_420,
	output logic [ycc_rgb_pkg::MCU_POS_W-1:0] mcu_w,
	output logic [ycc_rgb_pkg::MCU_POS_W-1:0] mcu_h
);
	import ycc_rgb_pkg::*;

	logic access;
	logic mapped;
	logic frame_done;

	assign access = psel & penable;
	assign mapped = paddr inside {ADDR_CTRL, ADDR_MCU_W, ADDR_MCU_H, ADDR_STATUS};
	assign pslverr = access & ~mapped;

	always_comb begin
		prdata = '0;
		case (paddr)
			ADDR_CTRL: prdata[0] = mode_420;
			ADDR_MCU_W: prdata[MCU_POS_W-1:0] = mcu_w;
			ADDR_MCU_H: prdata[MCU_POS_W-1:0] = mcu_h;
			ADDR_STATUS: prdata[0] = frame_done;
			default: prdata = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			mode_420 <= 1'b0;
			mcu_w <= MCU_POS_W'(1);
			mcu_h <= MCU_POS_W'(1);
			frame_done <= 1'b0;
		end else begin
			if (access && pwrite) begin
				case (paddr)
					ADDR_CTRL: mode_420 <= pwdata[0];
					ADDR_MCU_W: mcu_w <= pwdata[MCU_POS_W-1:0];
					ADDR_MCU_H: mcu_h <= pwdata[MCU_POS_W-1:0];
					ADDR_STATUS: begin
						// write 1 to clear
						if (pwdata[0]) begin
							frame_done <= 1'b0;
						end
					end
					default: ;
				endcase
			end
			// a new frame end wins over a clear in the same cycle
			if (frame_end) begin
				frame_done <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/ycc_rgb_pkg.sv ====
`default_nettype none

package ycc_rgb_pkg;

	// sample and pixel widths
	localparam int SAMPLE_W = 16;
	localparam int ROW_SAMPLES = 8;
	localparam int ROW_W = SAMPLE_W * ROW_SAMPLES;
	localparam int COLOR_W = 8;
	localparam int MCU_POS_W = 13;
	localparam int PIX_IDX_W = 8;

	// r, g, b, index, mcu x, mcu y, first, last
	localparam int PIX_WORD_W = 3 * COLOR_W + PIX_IDX_W + 2 * MCU_POS_W + 2;

	// ------------------------------------------------------------------
	// YCbCr to RGB coefficients, scaled by 4096
	// ------------------------------------------------------------------
	localparam logic [12:0] K_CR_R = 13'd5742;
	localparam logic [12:0] K_CB_G = 13'd1409;
	localparam logic [12:0] K_CR_G = 13'd2925;
	localparam logic [12:0] K_CB_B = 13'd7258;
	localparam int LEVEL_SHIFT = 128;

	// ------------------------------------------------------------------
	// APB register map
	// ------------------------------------------------------------------
	localparam logic [3:0] ADDR_CTRL = 4'h0;
	localparam logic [3:0] ADDR_MCU_W = 4'h4;
	localparam logic [3:0] ADDR_MCU_H = 4'h8;
	localparam logic [3:0] ADDR_STATUS = 4'hc;

	// pixel index inside an MCU
	// 16x16 grid for 4:2:0, 8x8 grid for 4:4:4
	typedef union packed {
		logic [PIX_IDX_W-1:0] raw;
		struct packed {
			logic [3:0] row;
			logic [3:0] col;
		} v420;
		struct packed {
			logic [1:0] spare;
			logic [2:0] row;
			logic [2:0] col;
		} v444;
	} pix_idx_u;

endpackage

`default_nettype wire
